// ==== csr_settings.svh ====
`ifndef CSR_SETTINGS_SVH
`define CSR_SETTINGS_SVH

////////////////////////////////////////////////////////////
// widths
////////////////////////////////////////////////////////////

`define CSR_XLEN          32            // data word
`define CSR_ADDR_W        12            // csr address
`define CORE_ID_W         4             // core id in mhartid
`define CLUSTER_ID_W      6             // cluster id in mhartid

////////////////////////////////////////////////////////////
// performance counter bank
////////////////////////////////////////////////////////////

`define PERF_CNT_NUM      11            // counter slots
`define PERF_CNT_W        32            // bits per counter
`define PCMR_RESET        2'b11         // global enable + saturate
`define PCCR_BASE_HI      7'b0111100    // addr[11:5] of 0x780..0x79f

////////////////////////////////////////////////////////////
// machine mode words
////////////////////////////////////////////////////////////

// mxl=1 (rv32), m (bit 12), i (bit 8), c (bit 2)
`define MISA_VALUE        32'h4000_1104
`define MSTATUS_MIE_BIT   3             // global irq enable
`define MSTATUS_MPIE_BIT  7             // previous irq enable

`endif

// ==== csr_pkg.sv ====
`include "csr_settings.svh"

package csr_pkg;

  // csr data word
  typedef logic [`CSR_XLEN-1:0] csr_data_t;

  // implemented csr addresses
  typedef enum logic [`CSR_ADDR_W-1:0] {
    CSR_MSTATUS = 12'h300,
    CSR_MISA    = 12'h301,
    CSR_MTVEC   = 12'h305,
    CSR_MEPC    = 12'h341,
    CSR_MCAUSE  = 12'h342,
    CSR_TSELECT = 12'h7A0,  // pcer lives here
    CSR_TDATA1  = 12'h7A1,  // pcmr lives here
    CSR_PCCR31  = 12'h79F,  // all counters at once
    CSR_MHARTID = 12'hF14
  } csr_num_e;

  // csr instruction op
  typedef enum logic [1:0] {
    CSR_OP_NONE  = 2'b00,
    CSR_OP_WRITE = 2'b01,
    CSR_OP_SET   = 2'b10,
    CSR_OP_CLEAR = 2'b11
  } csr_op_e;

  // trap cause as stored in mcause
  typedef struct packed {
    logic       irq;   // bit 31 of mcause
    logic [4:0] code;  // bits 4:0 of mcause
  } exc_cause_t;

  // the two stored mstatus bits
  typedef struct packed {
    logic mie;
    logic mpie;
  } mstatus_t;

  // only machine mode exists
  localparam logic [1:0] PRIV_LVL_M = 2'b11;

  // mpp field position in mstatus
  localparam int MSTATUS_MPP_LSB = 11;

endpackage

// ==== csr_op_unit.sv ====
`timescale 1ns/10ps

module csr_op_unit (
  input  logic               csr_access_i,  // csr instruction in flight
  input  csr_pkg::csr_op_e   csr_op_i,
  input  csr_pkg::csr_data_t csr_wdata_i,   // operand from the core
  input  csr_pkg::csr_data_t rdata_i,       // current value, fed back from top
  output csr_pkg::csr_data_t wdata_o,       // read-modify-write result
  output logic               we_o
);
  import csr_pkg::*;

  ////////////////////////////////////////////////////////////
  // read-modify-write data
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (csr_op_i)
      CSR_OP_SET: begin
        wdata_o = rdata_i | csr_wdata_i;   // csrrs
      end
      CSR_OP_CLEAR: begin
        wdata_o = rdata_i & ~csr_wdata_i;  // csrrc keeps old and not mask
      end
      default: begin
        wdata_o = csr_wdata_i;             // write and none pass bus data
      end
    endcase
  end

  // single strobe shared by every register
  // none op is a pure read
  assign we_o = csr_access_i && (csr_op_i != CSR_OP_NONE);

endmodule

// ==== trap_ctrl_fsm.sv ====
`timescale 1ns/10ps
`include "csr_settings.svh"

module trap_ctrl_fsm (
  input  logic               clk,
  input  logic               rst_n,
  input  csr_pkg::csr_num_e  csr_addr_i,
  input  csr_pkg::csr_data_t wdata_i,     // from op unit
  input  logic               we_i,
  input  logic               save_cause_i, // trap entry strobe
  input  logic               mret_i,       // mret strobe
  output csr_pkg::mstatus_t  mstatus_o,
  output logic               irq_enable_o
);
  import csr_pkg::*;

  mstatus_t state_q;  // mie/mpie pair is the state
  mstatus_t state_n;
  logic     mstatus_we;

  // write only counts when aimed at mstatus
  assign mstatus_we = we_i && (csr_addr_i == CSR_MSTATUS);

  ////////////////////////////////////////////////////////////
  // next state
  ////////////////////////////////////////////////////////////

  // priority is trap entry, mret, then csr write
  always_comb begin
    state_n = state_q;  // hold by default
    if (save_cause_i) begin
      // stack mie, block interrupts in handler
      state_n.mpie = state_q.mie;
      state_n.mie  = 1'b0;
    end else if (mret_i) begin
      // unstack mie
      state_n.mie  = state_q.mpie;
      state_n.mpie = 1'b1;
    end else if (mstatus_we) begin
      state_n.mie  = wdata_i[`MSTATUS_MIE_BIT];
      state_n.mpie = wdata_i[`MSTATUS_MPIE_BIT];
    end
  end

  ////////////////////////////////////////////////////////////
  // state register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      state_q <= '{mie: 1'b0, mpie: 1'b0};  // interrupts off out of reset
    end else begin
      state_q <= state_n;
    end
  end

  assign mstatus_o    = state_q;
  assign irq_enable_o = state_q.mie;  // straight to the core

endmodule

// ==== machine_csrs.sv ====
`timescale 1ns/10ps
`include "csr_settings.svh"

module machine_csrs (
  input  logic                     clk,
  input  logic                     rst_n,
  input  csr_pkg::csr_num_e        csr_addr_i,
  input  csr_pkg::csr_data_t       wdata_i,
  input  logic                     we_i,
  input  logic                     save_cause_i,  // trap entry
  input  logic                     save_if_i,     // trap on fetch pc
  input  csr_pkg::csr_data_t       pc_if_i,
  input  csr_pkg::csr_data_t       pc_id_i,
  input  csr_pkg::exc_cause_t      cause_i,
  input  csr_pkg::mstatus_t        mstatus_i,     // from trap fsm
  input  csr_pkg::csr_data_t       boot_addr_i,
  input  logic [`CORE_ID_W-1:0]    core_id_i,
  input  logic [`CLUSTER_ID_W-1:0] cluster_id_i,
  output csr_pkg::csr_data_t       rdata_o,
  output csr_pkg::csr_data_t       mepc_o
);
  import csr_pkg::*;

  csr_data_t  mepc_q;
  exc_cause_t mcause_q;
  csr_data_t  trap_pc;  // pc saved on trap entry

  // fetch pc if asked, decode pc otherwise
  assign trap_pc = save_if_i ? pc_if_i : pc_id_i;

  ////////////////////////////////////////////////////////////
  // mepc / mcause
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      mepc_q   <= '0;
      mcause_q <= '0;
    end else if (save_cause_i) begin
      // trap entry beats any csr write in the same cycle
      mepc_q   <= trap_pc;
      mcause_q <= cause_i;
    end else if (we_i) begin
      if (csr_addr_i == CSR_MEPC) begin
        mepc_q <= wdata_i;
      end
      if (csr_addr_i == CSR_MCAUSE) begin
        mcause_q <= '{irq: wdata_i[`CSR_XLEN-1], code: wdata_i[4:0]};
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // read mux
  ////////////////////////////////////////////////////////////

  always_comb begin
    rdata_o = '0;  // unmapped reads as zero
    case (csr_addr_i)
      CSR_MSTATUS: begin
        rdata_o[MSTATUS_MPP_LSB +: 2]   = PRIV_LVL_M;  // mpp fixed
        rdata_o[`MSTATUS_MPIE_BIT]      = mstatus_i.mpie;
        rdata_o[`MSTATUS_MIE_BIT]       = mstatus_i.mie;
      end
      CSR_MTVEC: begin
        rdata_o = boot_addr_i;  // vector base is boot address
      end
      CSR_MEPC: begin
        rdata_o = mepc_q;
      end
      CSR_MCAUSE: begin
        rdata_o[`CSR_XLEN-1] = mcause_q.irq;
        rdata_o[4:0]         = mcause_q.code;
      end
      CSR_MISA: begin
        rdata_o = `MISA_VALUE;
      end
      CSR_MHARTID: begin
        rdata_o[`CORE_ID_W-1:0]    = core_id_i;     // bits 3:0
        rdata_o[5 +: `CLUSTER_ID_W] = cluster_id_i; // bits 10:5
      end
      default: begin
        rdata_o = '0;
      end
    endcase
  end

  assign mepc_o = mepc_q;

endmodule

// ==== perf_counters.sv ====
`timescale 1ns/10ps
`include "csr_settings.svh"

module perf_counters (
  input  logic               clk,
  input  logic               rst_n,
  input  csr_pkg::csr_num_e  csr_addr_i,
  input  logic               csr_access_i,
  input  csr_pkg::csr_data_t wdata_i,
  input  logic               we_i,
  input  logic               if_valid_i,      // new instr from fetch
  input  logic               id_valid_i,      // decode stage done
  input  logic               is_compressed_i, // rvc instr in decode
  input  logic               is_decoding_i,   // controller decoding
  input  logic               imiss_i,         // fetch stall
  input  logic               pc_set_i,        // redirect
  input  logic               jump_i,
  input  logic               branch_i,
  input  logic               branch_taken_i,
  input  logic               mem_load_i,
  input  logic               mem_store_i,
  output logic               perf_hit_o,
  output csr_pkg::csr_data_t perf_rdata_o
);
  import csr_pkg::*;

  logic [`PERF_CNT_NUM-1:0] cnt_evt;                 // raw events per slot
  logic [`PERF_CNT_NUM-1:0] cnt_inc;
  logic [`PERF_CNT_NUM-1:0] cnt_inc_q;               // registered increment request
  logic [`PERF_CNT_NUM-1:0] pcer_q;                  // per-slot enable
  logic [1:0]               pcmr_q;                  // [0] global en, [1] saturate
  logic [`PERF_CNT_W-1:0]   cnt_q [`PERF_CNT_NUM];
  logic [`PERF_CNT_W-1:0]   cnt_n [`PERF_CNT_NUM];
  logic                     is_pcer;
  logic                     is_pcmr;
  logic                     is_pccr;                 // inside the counter window
  logic                     pccr_all;
  logic [4:0]               pccr_idx;

  ////////////////////////////////////////////////////////////
  // event map
  ////////////////////////////////////////////////////////////

  assign cnt_evt[0]  = 1'b1;                 // cycles
  assign cnt_evt[1]  = if_valid_i;           // fetched instrs
  assign cnt_evt[2]  = 1'b0;                 // reserved
  assign cnt_evt[3]  = 1'b0;                 // reserved
  assign cnt_evt[4]  = imiss_i & ~pc_set_i;  // stalls without redirect
  assign cnt_evt[5]  = mem_load_i;
  assign cnt_evt[6]  = mem_store_i;
  assign cnt_evt[7]  = jump_i;
  assign cnt_evt[8]  = branch_i;
  assign cnt_evt[9]  = branch_taken_i;
  assign cnt_evt[10] = id_valid_i & is_decoding_i & is_compressed_i;

  assign cnt_inc = cnt_evt & pcer_q & {`PERF_CNT_NUM{pcmr_q[0]}};

  // address decode only for a live access
  assign is_pcer  = csr_access_i && (csr_addr_i == CSR_TSELECT);
  assign is_pcmr  = csr_access_i && (csr_addr_i == CSR_TDATA1);
  assign is_pccr  = csr_access_i && (csr_addr_i[11:5] == `PCCR_BASE_HI);
  assign pccr_all = csr_access_i && (csr_addr_i == CSR_PCCR31);
  assign pccr_idx = csr_addr_i[4:0];

  assign perf_hit_o = is_pcer | is_pcmr | is_pccr;  // pccr31 sits in the window

  // idx at or above slot count reads zero
  always_comb begin
    perf_rdata_o = '0;
    if (is_pcer) begin
      perf_rdata_o[`PERF_CNT_NUM-1:0] = pcer_q;
    end else if (is_pcmr) begin
      perf_rdata_o[1:0] = pcmr_q;
    end else if (is_pccr) begin
      for (int c = 0; c < `PERF_CNT_NUM; c++) begin
        if (pccr_idx == c) begin
          perf_rdata_o = cnt_q[c];
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // counter next value
  ////////////////////////////////////////////////////////////

  always_comb begin
    for (int c = 0; c < `PERF_CNT_NUM; c++) begin
      cnt_n[c] = cnt_q[c];
      // stuck at all-ones only when saturating
      if (cnt_inc_q[c] && ((cnt_q[c] != '1) || !pcmr_q[1])) begin
        cnt_n[c] = cnt_q[c] + 1'b1;
      end
      if (we_i && is_pccr && (pccr_all || (pccr_idx == c))) begin
        cnt_n[c] = wdata_i;  // write beats increment
      end
    end
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      pcer_q    <= '0;           // nothing counts
      pcmr_q    <= `PCMR_RESET;
      cnt_inc_q <= '0;
      for (int c = 0; c < `PERF_CNT_NUM; c++) begin
        cnt_q[c] <= '0;
      end
    end else begin
      cnt_inc_q <= cnt_inc;
      if (we_i && is_pcer) begin
        pcer_q <= wdata_i[`PERF_CNT_NUM-1:0];
      end
      if (we_i && is_pcmr) begin
        pcmr_q <= wdata_i[1:0];
      end
      for (int c = 0; c < `PERF_CNT_NUM; c++) begin
        cnt_q[c] <= cnt_n[c];
      end
    end
  end

endmodule

// ==== cs_registers.sv ====
`timescale 1ns/10ps
`include "csr_settings.svh"

module cs_registers (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic [`CORE_ID_W-1:0]    core_id_i,
  input  logic [`CLUSTER_ID_W-1:0] cluster_id_i,
  input  csr_pkg::csr_data_t       boot_addr_i,
  // csr port from the core
  input  logic                     csr_access_i,
  input  csr_pkg::csr_num_e        csr_addr_i,
  input  csr_pkg::csr_data_t       csr_wdata_i,
  input  csr_pkg::csr_op_e         csr_op_i,
  output csr_pkg::csr_data_t       csr_rdata_o,
  // trap control
  output logic                     m_irq_enable_o,
  output csr_pkg::csr_data_t       mepc_o,
  input  csr_pkg::csr_data_t       pc_if_i,
  input  csr_pkg::csr_data_t       pc_id_i,
  input  logic                     csr_save_if_i,
  input  logic                     csr_save_id_i,      // decode pc is the fallback
  input  logic                     csr_save_cause_i,
  input  logic                     csr_restore_mret_i,
  input  csr_pkg::exc_cause_t      csr_cause_i,
  // perf events
  input  logic                     if_valid_i,
  input  logic                     id_valid_i,
  input  logic                     is_compressed_i,
  input  logic                     is_decoding_i,
  input  logic                     imiss_i,
  input  logic                     pc_set_i,
  input  logic                     jump_i,
  input  logic                     branch_i,
  input  logic                     branch_taken_i,
  input  logic                     mem_load_i,
  input  logic                     mem_store_i
);
  import csr_pkg::*;

  csr_data_t wdata;          // rmw result
  logic      we;
  mstatus_t  mstatus;
  csr_data_t machine_rdata;
  logic      perf_hit;
  csr_data_t perf_rdata;

  csr_op_unit op_unit_i (
    .csr_access_i (csr_access_i),
    .csr_op_i     (csr_op_i),
    .csr_wdata_i  (csr_wdata_i),
    .rdata_i      (csr_rdata_o),   // old value for set/clear
    .wdata_o      (wdata),
    .we_o         (we)
  );

  trap_ctrl_fsm trap_ctrl_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .csr_addr_i   (csr_addr_i),
    .wdata_i      (wdata),
    .we_i         (we),
    .save_cause_i (csr_save_cause_i),
    .mret_i       (csr_restore_mret_i),
    .mstatus_o    (mstatus),
    .irq_enable_o (m_irq_enable_o)
  );

  machine_csrs machine_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .csr_addr_i   (csr_addr_i),
    .wdata_i      (wdata),
    .we_i         (we),
    .save_cause_i (csr_save_cause_i),
    .save_if_i    (csr_save_if_i),
    .pc_if_i      (pc_if_i),
    .pc_id_i      (pc_id_i),
    .cause_i      (csr_cause_i),
    .mstatus_i    (mstatus),
    .boot_addr_i  (boot_addr_i),
    .core_id_i    (core_id_i),
    .cluster_id_i (cluster_id_i),
    .rdata_o      (machine_rdata),
    .mepc_o       (mepc_o)
  );

  perf_counters perf_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .csr_addr_i      (csr_addr_i),
    .csr_access_i    (csr_access_i),
    .wdata_i         (wdata),
    .we_i            (we),
    .if_valid_i      (if_valid_i),
    .id_valid_i      (id_valid_i),
    .is_compressed_i (is_compressed_i),
    .is_decoding_i   (is_decoding_i),
    .imiss_i         (imiss_i),
    .pc_set_i        (pc_set_i),
    .jump_i          (jump_i),
    .branch_i        (branch_i),
    .branch_taken_i  (branch_taken_i),
    .mem_load_i      (mem_load_i),
    .mem_store_i     (mem_store_i),
    .perf_hit_o      (perf_hit),
    .perf_rdata_o    (perf_rdata)
  );

  // counter bank answers its own window, machine csrs the rest
  assign csr_rdata_o = perf_hit ? perf_rdata : machine_rdata;

endmodule

// ==== tb_cs_registers.sv ====
`timescale 1ns/10ps
`include "csr_settings.svh"

module tb_cs_registers;
  import csr_pkg::*;

  // expected register state advanced once per clock
  typedef struct packed {
    csr_data_t                                 mepc;
    exc_cause_t                                cause;
    mstatus_t                                  st;
    logic [`PERF_CNT_NUM-1:0]                  pcer;
    logic [1:0]                                pcmr;
    logic [`PERF_CNT_NUM-1:0]                  inc;   // increment requests in flight
    logic [`PERF_CNT_NUM-1:0][`PERF_CNT_W-1:0] cnt;
  } model_t;

  logic       clk;
  logic       rst_n;
  logic       access;
  csr_num_e   addr;
  csr_op_e    op;
  csr_data_t  wdata, rdata, mepc, pc_if, pc_id, boot_addr;
  logic       irq_en, save_if, save_id, save_cause, mret, mem_load;
  exc_cause_t cause;
  logic [3:0] core_id;
  logic [5:0] cluster_id;

  model_t     cur;          // what the DUT shows now
  model_t     nxt;          // what it shows after the next edge
  logic       chk_en;
  string      test_name;
  int         seed = 85162;
  logic       trap_req, mret_req, load_req, trap_if;  // strobes for the next bus cycle
  csr_data_t  trap_pc_if, trap_pc_id;
  exc_cause_t trap_cause;

  cs_registers cs_registers_i (
    .clk (clk), .rst_n (rst_n),
    .core_id_i (core_id), .cluster_id_i (cluster_id), .boot_addr_i (boot_addr),
    .csr_access_i (access), .csr_addr_i (addr), .csr_wdata_i (wdata), .csr_op_i (op),
    .csr_rdata_o (rdata), .m_irq_enable_o (irq_en), .mepc_o (mepc),
    .pc_if_i (pc_if), .pc_id_i (pc_id), .csr_save_if_i (save_if), .csr_save_id_i (save_id),
    .csr_save_cause_i (save_cause), .csr_restore_mret_i (mret), .csr_cause_i (cause),
    .if_valid_i (1'b0), .id_valid_i (1'b0), .is_compressed_i (1'b0), .is_decoding_i (1'b0),
    .imiss_i (1'b0), .pc_set_i (1'b0), .jump_i (1'b0), .branch_i (1'b0),
    .branch_taken_i (1'b0), .mem_load_i (mem_load), .mem_store_i (1'b0)  // loads only
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;  // 100 ns period
  end

  ////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////

  function automatic csr_data_t op_ref(input csr_op_e o, input csr_data_t old,
                                       input csr_data_t d);
    case (o)
      CSR_OP_SET:   return old | d;
      CSR_OP_CLEAR: return old & ~d;
      default:      return d;
    endcase
  endfunction

  // {mie, mpie} with trap over mret over write
  function automatic mstatus_t status_ref(input mstatus_t s, input logic trap,
                                          input logic ret, input logic wr, input csr_data_t d);
    if (trap) return {1'b0, s.mie};
    if (ret) return {s.mpie, 1'b1};
    if (wr) return {d[3], d[7]};
    return s;
  endfunction

  function automatic csr_data_t misa_ref();
    csr_data_t w;
    w = '0;
    w[31:30] = 2'd1;  // mxl rv32
    w[12] = 1'b1;     // m
    w[8] = 1'b1;      // i
    w[2] = 1'b1;      // c
    return w;
  endfunction

  function automatic csr_data_t hartid_ref(input logic [3:0] core, input logic [5:0] cluster);
    return {21'b0, cluster, 1'b0, core};  // cluster 10:5, core 3:0
  endfunction

  function automatic logic [31:0] cnt_next_ref(input logic [31:0] c, input logic sat);
    if (c == 32'hffff_ffff) return sat ? c : '0;  // stick or wrap
    return c + 1;
  endfunction

  function automatic csr_num_e counter_addr(input int idx);
    return csr_num_e'(12'h780 | idx[4:0]);
  endfunction

  // expected read data of the current cycle
  function automatic csr_data_t read_ref(input logic acc, input csr_num_e a);
    logic [11:0] ra;
    ra = a;
    if (acc && (ra >= 12'h780) && (ra <= 12'h79f)) begin
      return (ra[4:0] < 5'd11) ? cur.cnt[ra[4:0]] : '0;  // idx 11+ reads zero
    end
    case (a)
      CSR_MSTATUS: return {19'b0, 2'b11, 3'b0, cur.st.mpie, 3'b0, cur.st.mie, 3'b0};
      CSR_MISA:    return misa_ref();
      CSR_MTVEC:   return boot_addr;
      CSR_MEPC:    return cur.mepc;
      CSR_MCAUSE:  return {cur.cause.irq, 26'b0, cur.cause.code};
      CSR_MHARTID: return hartid_ref(core_id, cluster_id);
      CSR_TSELECT: return acc ? {21'b0, cur.pcer} : '0;
      CSR_TDATA1:  return acc ? {30'b0, cur.pcmr} : '0;
      default:     return '0;
    endcase
  endfunction

  ////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////

  task automatic fail_run();
    $display("Simulation failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_data(input string name, input csr_data_t exp, input csr_data_t act);
    if (act !== exp) begin
      $display("Error %s: expected %h, actual %h", name, exp, act);
      fail_run();
    end
  endtask

  task automatic check_status(input string name, input mstatus_t exp, input mstatus_t act);
    if (act !== exp) begin
      $display("Error %s: expected mie/mpie %b, actual %b", name, exp, act);
      fail_run();
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Error %s: expected %b, actual %b", name, exp, act);
      fail_run();
    end
  endtask

  // mid-cycle compare of everything observable
  always @(negedge clk) begin
    if (chk_en) begin
      check_data(test_name, read_ref(access, addr), rdata);
      check_data({test_name, " mepc_o"}, cur.mepc, mepc);
      check_bit({test_name, " m_irq_enable_o"}, cur.st.mie, irq_en);
    end
  end

  ////////////////////////////////////////////////////////////
  // bus cycle and waits
  ////////////////////////////////////////////////////////////

  task automatic bus(input logic acc, input csr_num_e a, input csr_op_e o, input csr_data_t d);
    csr_data_t wd;
    logic      we;
    @(posedge clk);
    cur = nxt;  // last cycle's update lands on this edge
    access     <= acc;
    addr       <= a;
    op         <= o;
    wdata      <= d;
    save_cause <= trap_req;
    save_if    <= trap_req && trap_if;
    save_id    <= trap_req && !trap_if;
    mret       <= mret_req;
    pc_if      <= trap_pc_if;
    pc_id      <= trap_pc_id;
    cause      <= trap_cause;
    mem_load   <= load_req;
    wd = op_ref(o, read_ref(acc, a), d);
    we = acc && (o != CSR_OP_NONE);
    nxt.st = status_ref(cur.st, trap_req, mret_req, we && (a == CSR_MSTATUS), wd);
    if (trap_req) begin
      nxt.mepc  = trap_if ? trap_pc_if : trap_pc_id;
      nxt.cause = trap_cause;
    end else if (we && (a == CSR_MEPC)) begin
      nxt.mepc = wd;
    end else if (we && (a == CSR_MCAUSE)) begin
      nxt.cause = {wd[31], wd[4:0]};
    end
    if (we && (a == CSR_TSELECT)) nxt.pcer = wd[10:0];
    if (we && (a == CSR_TDATA1)) nxt.pcmr = wd[1:0];
    for (int c = 0; c < 11; c++) begin
      nxt.cnt[c] = cur.inc[c] ? cnt_next_ref(cur.cnt[c], cur.pcmr[1]) : cur.cnt[c];
      if (we && (a[11:5] == 7'h3c) && ((a == CSR_PCCR31) || (a[4:0] == c))) begin
        nxt.cnt[c] = wd;  // write beats increment
      end
    end
    // slot 0 counts cycles, slot 5 loads
    nxt.inc = {5'b0, load_req, 4'b0, 1'b1} & cur.pcer & {11{cur.pcmr[0]}};
    @(negedge clk);
  endtask

  // polls a csr until it shows the wanted value
  task automatic wait_read(input csr_num_e a, input csr_data_t want, input int limit);
    int n_cyc;
    n_cyc = 0;
    bus(1'b1, a, CSR_OP_NONE, '0);
    while ((rdata !== want) && (n_cyc < limit)) begin
      n_cyc++;
      bus(1'b1, a, CSR_OP_NONE, '0);
    end
    if (rdata !== want) begin
      $display("Timeout in %s: csr %h never reached %h", test_name, a, want);
      fail_run();
    end
  endtask

  task automatic ro_probe(input csr_num_e a);
    bus(1'b1, a, CSR_OP_WRITE, $random(seed));    // ignored
    bus(1'b1, a, CSR_OP_SET, 32'hffff_ffff);
    bus(1'b1, a, CSR_OP_NONE, '0);
  endtask

  ////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] rnd;
    rst_n = 1'b0;
    access = 1'b0;
    addr = CSR_MSTATUS;
    op = CSR_OP_NONE;
    wdata = '0;
    {save_if, save_id, save_cause, mret, mem_load} = '0;
    pc_if = '0;
    pc_id = '0;
    cause = '0;
    core_id = 4'h9;
    cluster_id = 6'h2d;
    boot_addr = 32'h1c00_8080;
    {trap_req, mret_req, load_req, trap_if} = '0;
    trap_pc_if = '0;
    trap_pc_id = '0;
    trap_cause = '0;
    chk_en = 1'b0;
    test_name = "reset";
    cur = '0;
    cur.pcmr = 2'b11;  // enabled, saturating
    nxt = cur;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    chk_en = 1'b1;

    test_name = "mepc op rule";  // access low a quarter of the time
    for (int i = 0; i < 40; i++) begin
      rnd = $random(seed);
      bus(rnd[0] | rnd[1], CSR_MEPC, csr_op_e'(rnd[3:2]), $random(seed));
    end

    test_name = "mstatus write";
    for (int i = 0; i < 16; i++) begin
      rnd = $random(seed);
      bus(1'b1, CSR_MSTATUS, csr_op_e'(rnd[1:0]), $random(seed));
    end

    // fetch pc first, decode pc second
    for (int i = 0; i < 2; i++) begin
      test_name = "trap entry";
      bus(1'b1, CSR_MSTATUS, CSR_OP_WRITE, 32'h0000_0008);  // mie on
      trap_if = (i == 0);
      trap_pc_if = $random(seed);
      trap_pc_id = $random(seed);
      trap_cause = {i[0], 5'd11};
      trap_req = 1'b1;
      bus(1'b1, CSR_MEPC, CSR_OP_WRITE, 32'h0bad_cafe);  // lost to the trap
      trap_req = 1'b0;
      bus(1'b1, CSR_MEPC, CSR_OP_NONE, '0);
      check_data("trap mepc", trap_if ? trap_pc_if : trap_pc_id, rdata);
      bus(1'b1, CSR_MCAUSE, CSR_OP_NONE, '0);
      mret_req = 1'b1;
      bus(1'b1, CSR_MSTATUS, CSR_OP_NONE, '0);
      check_status("trap mstatus", 2'b01, {rdata[3], rdata[7]});
      mret_req = 1'b0;
      test_name = "mret";
      bus(1'b1, CSR_MSTATUS, CSR_OP_NONE, '0);
      check_status("mret mstatus", 2'b11, {rdata[3], rdata[7]});
    end

    test_name = "read-only csrs";
    ro_probe(CSR_MTVEC);
    ro_probe(CSR_MISA);
    ro_probe(CSR_MHARTID);
    ro_probe(csr_num_e'(12'h123));  // unmapped

    test_name = "load counter";
    bus(1'b1, CSR_TSELECT, CSR_OP_WRITE, 32'h20);  // slot 5 only
    bus(1'b1, counter_addr(5), CSR_OP_WRITE, '0);
    load_req = 1'b1;
    repeat (7) bus(1'b1, counter_addr(5), CSR_OP_NONE, '0);
    load_req = 1'b0;
    wait_read(counter_addr(5), 32'd7, 8);

    test_name = "reserved slot";
    bus(1'b1, CSR_TSELECT, CSR_OP_SET, 32'h4);
    load_req = 1'b1;
    repeat (4) bus(1'b1, counter_addr(2), CSR_OP_NONE, '0);

    test_name = "counter freeze";
    bus(1'b1, CSR_TDATA1, CSR_OP_CLEAR, 32'h1);
    repeat (6) bus(1'b1, counter_addr(5), CSR_OP_NONE, '0);
    load_req = 1'b0;

    test_name = "saturate";
    bus(1'b1, CSR_TDATA1, CSR_OP_WRITE, 32'h3);
    bus(1'b1, counter_addr(5), CSR_OP_WRITE, 32'hffff_ffff);
    load_req = 1'b1;
    repeat (5) bus(1'b1, counter_addr(5), CSR_OP_NONE, '0);
    load_req = 1'b0;
    wait_read(counter_addr(5), 32'hffff_ffff, 4);

    test_name = "wrap";
    bus(1'b1, CSR_TDATA1, CSR_OP_WRITE, 32'h1);
    bus(1'b1, counter_addr(5), CSR_OP_WRITE, 32'hffff_ffff);
    load_req = 1'b1;
    repeat (3) bus(1'b1, counter_addr(5), CSR_OP_NONE, '0);
    load_req = 1'b0;
    wait_read(counter_addr(5), 32'd2, 6);  // three past all-ones

    test_name = "all counter write";
    bus(1'b1, CSR_TSELECT, CSR_OP_WRITE, '0);
    rnd = $random(seed);
    bus(1'b1, CSR_PCCR31, CSR_OP_WRITE, rnd);
    for (int c = 0; c < 12; c++) begin
      bus(1'b1, counter_addr(c), CSR_OP_NONE, '0);
      check_data("all counter write", (c < 11) ? rnd : '0, rdata);
    end

    $display("Simulation passed");
    $finish;
  end

endmodule

// ==== files.f ====
+incdir+.
csr_pkg.sv
csr_op_unit.sv
trap_ctrl_fsm.sv
machine_csrs.sv
perf_counters.sv
cs_registers.sv
tb_cs_registers.sv
